/* files.f */
+incdir+logic
logic/cache_addr_pkg.sv
logic/cache_ctrl_pkg.sv
logic/cache_data.sv
logic/cache_bank.sv
logic/cache_controller.sv
logic/cache_top.sv
verification/tb_clock_gen.sv
verification/tb_cache_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_cache_top
FILE_LIST := files.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILE_LIST)) logic/cache_defines.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Verdict comes from the log, a missing pass line counts as failure
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_cache_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the data cache: directed and random core traffic, a
// block memory model with random read latency and a shadow reference
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cache_defines.svh"

module tb_cache_top import cache_addr_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int   RANDOM_OPS = 400;
    localparam int   MAX_CYCLES = RANDOM_OPS * 20 + 2000;  // Worst-case miss each, plus margin
    localparam tag_t TAGS [4]   = '{20'h12345, 20'h0beef, 20'hfffff, 20'h00001};

    logic   clk, reset;
    logic   req_valid, req_write, rsp_valid;
    addr_t  req_addr;
    word_t  req_wdata, rsp_rdata;
    logic   mem_req_valid, mem_req_write;
    addr_t  mem_req_addr;
    block_t mem_req_wdata;
    logic   mem_rsp_valid = 1'b0;
    block_t mem_rsp_data  = '0;

    word_t  mem_words [addr_t];     // Written words only, the rest is init_word
    word_t  shadow_words [addr_t];  // Contents as the core should see them
    word_t  expect_q [$];           // One expected rsp_rdata per request
    integer seed = 32'hd3e7_6a1c;
    int     cycle_count = 0;
    int     rd_pulses = 0, wr_pulses = 0;
    int     last_rd_cycle = 0, last_wr_cycle = 0;
    addr_t  last_rd_addr = '0, last_wr_addr = '0;
    logic   fetch_pending = 1'b0;
    int     fetch_delay = 0;
    addr_t  fetch_addr = '0;
    int     access_cycles, access_rd, access_wr;  // Result of the last access

    tb_clock_gen u_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    cache_top u_cache_top (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .rsp_valid     (rsp_valid),
        .rsp_rdata     (rsp_rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    function automatic addr_t word_addr(addr_t addr);
        return {addr[31:2], 2'b00};
    endfunction

    // Power-on memory word, every address bit feeds in
    function automatic word_t init_word(addr_t addr);
        return (addr ^ 32'h5a3c_96e1) * 32'h0001_0003 + {addr[7:0], addr[31:8]};
    endfunction

    function automatic word_t mem_word(addr_t addr);
        if (mem_words.exists(word_addr(addr))) begin
            return mem_words[word_addr(addr)];
        end
        return init_word(word_addr(addr));
    endfunction

    // Expected word, from the shadow copy only
    function automatic word_t ref_read(addr_t addr);
        if (shadow_words.exists(word_addr(addr))) begin
            return shadow_words[word_addr(addr)];
        end
        return init_word(word_addr(addr));
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("** Error: %s = %08h, expected %08h (cycle %0d)", name, got, expected,
                     cycle_count);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Timeout");
        end
    end

    // Block memory, posted writes, reads answered after 1 to 8 cycles
    always @(negedge clk) begin : memory_model
        block_t fill;
        mem_rsp_valid = 1'b0;  // Single cycle pulse
        if (fetch_pending) begin
            if (fetch_delay == 0) begin
                for (int w = 0; w < `NUM_WORDS_PER_BLOCK; w++) begin
                    fill[w] = mem_word(fetch_addr + 32'(4 * w));
                end
                mem_rsp_data  = fill;
                mem_rsp_valid = 1'b1;
                fetch_pending = 1'b0;
            end else begin
                fetch_delay--;
            end
        end
        if (mem_req_valid && mem_req_write) begin
            for (int w = 0; w < `NUM_WORDS_PER_BLOCK; w++) begin
                mem_words[mem_req_addr + 32'(4 * w)] = mem_req_wdata[w];
            end
            wr_pulses++;
            last_wr_addr  = mem_req_addr;
            last_wr_cycle = cycle_count;
        end else if (mem_req_valid) begin
            rd_pulses++;
            last_rd_addr  = mem_req_addr;
            last_rd_cycle = cycle_count;
            fetch_pending = 1'b1;
            fetch_addr    = mem_req_addr;
            fetch_delay   = int'($unsigned($random(seed)) % 8);  // Next edge at the earliest
        end
    end

    // Compares every core response and every write-back block
    always @(negedge clk) begin : compare_responses
        word_t expected;
        if (!reset && rsp_valid && expect_q.size() == 0) begin
            $display("Response strobe seen with no request outstanding");
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stray response");
        end else if (!reset && rsp_valid) begin
            expected = expect_q.pop_front();
            check_value("rsp_rdata", rsp_rdata, expected);
        end
        if (!reset && mem_req_valid && mem_req_write) begin
            for (int w = 0; w < `NUM_WORDS_PER_BLOCK; w++) begin
                check_value($sformatf("mem_req_wdata[%0d]", w), mem_req_wdata[w],
                            ref_read(mem_req_addr + 32'(4 * w)));
            end
        end
    end

    // One core request, held until rsp_valid, called on a falling edge
    task automatic access(input logic write, input addr_t addr, input word_t wdata);
        int rd_start;
        int wr_start;
        rd_start  = rd_pulses;
        wr_start  = wr_pulses;
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        if (write) begin
            shadow_words[word_addr(addr)] = wdata;
            expect_q.push_back('0);  // Writes answer with zero
        end else begin
            expect_q.push_back(ref_read(addr));
        end
        access_cycles = 0;
        do begin
            @(negedge clk);
            access_cycles++;
        end while (!rsp_valid);
        access_rd = rd_pulses - rd_start;
        access_wr = wr_pulses - wr_start;
    endtask

    initial begin : stimulus
        addr_t a_addr;
        addr_t b_addr;
        word_t sel;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        wait (!reset);
        @(negedge clk);

        repeat (4) begin  // Quiet after reset
            check_value("rsp_valid", 32'(rsp_valid), 32'h0);
            check_value("mem_req_valid", 32'(mem_req_valid), 32'h0);
            @(negedge clk);
        end

        a_addr = {20'h12345, 8'h40, 2'd2, 2'b00};  // Clean read miss
        access(1'b0, a_addr, '0);
        check_value("read pulses", access_rd, 1);
        check_value("write pulses", access_wr, 0);
        check_value("mem_req_addr", last_rd_addr, {a_addr[31:4], 4'h0});

        access(1'b1, {a_addr[31:4], 4'h4}, 32'hcafe_f00d);  // Write hit on word 1
        check_value("write hit pulses", access_rd + access_wr, 0);
        for (int w = 0; w < `NUM_WORDS_PER_BLOCK; w++) begin
            access(1'b0, {a_addr[31:4], w[1:0], 2'b00}, '0);
        end

        access(1'b0, a_addr, '0);  // Resident line
        check_value("resident pulses", access_rd + access_wr, 0);
        check_value("resident latency", access_cycles, 1);

        b_addr = {20'h0beef, 8'h40, 4'h0};  // Same index, other tag, victim dirty
        access(1'b0, b_addr, '0);
        check_value("conflict write pulses", access_wr, 1);
        check_value("conflict read pulses", access_rd, 1);
        check_value("write-back mem_req_addr", last_wr_addr, {a_addr[31:4], 4'h0});
        check_value("fetch mem_req_addr", last_rd_addr, b_addr);
        check_value("write-back before fetch", 32'(last_wr_cycle < last_rd_cycle), 32'h1);
        access(1'b0, {a_addr[31:4], 4'h4}, '0);  // Written word back from memory

        for (int i = 0; i < RANDOM_OPS; i++) begin
            sel    = $random(seed);
            b_addr = {TAGS[sel[1:0]], index_t'(sel[4:2]) * 8'd37, sel[6:5], 2'b00};
            access(sel[7], b_addr, $random(seed));
        end

        req_valid = 1'b0;
        repeat (4) @(negedge clk);
        check_value("responses outstanding", expect_q.size(), 0);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source, 40 ns period, reset high for
// the first three rising edges and released on a falling edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;  // Away from the sampling edge
    end

endmodule

/* logic/cache_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the write-back data cache, core port on one side and block
// memory port on the other; controller and bank wired together here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cache_top import cache_addr_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    // Core side, request held until rsp_valid
    input  logic   req_valid,
    input  logic   req_write,
    input  addr_t  req_addr,
    input  word_t  req_wdata,
    output logic   rsp_valid,
    output word_t  rsp_rdata,
    // Memory side
    output logic   mem_req_valid,
    output logic   mem_req_write,
    output addr_t  mem_req_addr,
    output block_t mem_req_wdata,
    input  logic   mem_rsp_valid,
    input  block_t mem_rsp_data
);

    logic   lookup_en;
    logic   fill_en;
    logic   hit;
    logic   miss;
    word_t  rdata;
    logic   evict_dirty;
    addr_t  evict_addr;
    block_t evict_data;

    cache_controller u_cache_controller (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .hit           (hit),
        .miss          (miss),
        .evict_dirty   (evict_dirty),
        .rdata         (rdata),
        .evict_addr    (evict_addr),
        .evict_data    (evict_data),
        .mem_rsp_valid (mem_rsp_valid),
        .lookup_en     (lookup_en),
        .fill_en       (fill_en),
        .rsp_valid     (rsp_valid),
        .rsp_rdata     (rsp_rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata)
    );

    cache_bank u_cache_bank (
        .clk         (clk),
        .reset       (reset),
        .lookup_en   (lookup_en),
        .fill_en     (fill_en),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .fill_data   (mem_rsp_data),  // Straight from memory
        .hit         (hit),
        .miss        (miss),
        .rdata       (rdata),
        .evict_dirty (evict_dirty),
        .evict_addr  (evict_addr),
        .evict_data  (evict_data)
    );

endmodule

/* logic/cache_controller.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Miss FSM of the cache: registers the core response on a hit and
// issues the write-back and fetch pulses to memory on a miss
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cache_controller
    import cache_addr_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   req_valid,
    input  addr_t  req_addr,
    input  logic   hit,
    input  logic   miss,
    input  logic   evict_dirty,
    input  word_t  rdata,
    input  addr_t  evict_addr,
    input  block_t evict_data,
    input  logic   mem_rsp_valid,
    output logic   lookup_en,
    output logic   fill_en,
    output logic   rsp_valid,
    output word_t  rsp_rdata,
    output logic   mem_req_valid,
    output logic   mem_req_write,
    output addr_t  mem_req_addr,
    output block_t mem_req_wdata
);

    ctrl_state_t state;
    addr_t       fetch_addr;

    assign lookup_en = (state == IDLE) && req_valid;
    assign fill_en   = (state == RECV_FILL) && mem_rsp_valid;

    // Block of the held request
    assign fetch_addr = block_addr(addr_tag(req_addr), addr_index(req_addr));

    // State and strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= IDLE;
            rsp_valid     <= 1'b0;
            mem_req_valid <= 1'b0;
        end else begin
            rsp_valid     <= 1'b0;  // Both strobes are single cycle
            mem_req_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (hit) begin
                        rsp_valid <= 1'b1;
                    end else if (miss) begin
                        mem_req_valid <= 1'b1;  // Write-back or fetch, first pulse
                        state         <= evict_dirty ? SEND_WB : SEND_FETCH;
                    end
                end
                SEND_WB: begin
                    mem_req_valid <= 1'b1;  // Fetch right behind the posted write
                    state         <= SEND_FETCH;
                end
                SEND_FETCH: state <= RECV_FILL;
                RECV_FILL: begin
                    if (mem_rsp_valid) begin
                        state <= IDLE;  // Look the request up again
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Response word and memory payload
    always_ff @(posedge clk) begin
        if ((state == IDLE) && hit) begin
            rsp_rdata <= rdata;  // Already zero for writes
        end
        if ((state == IDLE) && miss) begin
            mem_req_write <= evict_dirty;
            mem_req_addr  <= evict_dirty ? evict_addr : fetch_addr;
            mem_req_wdata <= evict_data;  // Ignored by memory on a read
        end else if (state == SEND_WB) begin
            mem_req_write <= 1'b0;
            mem_req_addr  <= fetch_addr;
        end
    end

    // Only one read outstanding, a response outside the wait state is stray
    a_rsp_in_fill: assert property (
        @(posedge clk) disable iff (reset)
        mem_rsp_valid |-> (state == RECV_FILL)
    ) else $error("cache_controller: mem_rsp_valid outside RECV_FILL");

    // Refill installs the tag of req_addr, so the core must hold it
    a_req_held: assert property (
        @(posedge clk) disable iff (reset)
        (state != IDLE) |-> $stable(req_addr)
    ) else $error("cache_controller: req_addr changed during miss");

endmodule

/* logic/cache_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache bank with tag compare and hit/miss decision over the line
// storage, read word select, write enables and the victim address and data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cache_defines.svh"

module cache_bank import cache_addr_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   lookup_en,    // Controller in IDLE with a request
    input  logic   fill_en,      // Memory block arriving
    input  logic   req_write,
    input  addr_t  req_addr,
    input  word_t  req_wdata,
    input  block_t fill_data,
    output logic   hit,
    output logic   miss,
    output word_t  rdata,
    output logic   evict_dirty,
    output addr_t  evict_addr,
    output block_t evict_data
);

    // Request address fields
    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;

    // Indexed line as stored
    tag_t   tag_use;
    block_t data_use;
    logic   valid_use;
    logic   dirty_use;

    logic [`NUM_WORDS_PER_BLOCK-1:0] word_we;
    block_t                          write_block;

    assign req_tag    = addr_tag(req_addr);
    assign req_index  = addr_index(req_addr);
    assign req_offset = addr_offset(req_addr);

    // Lookup result
    assign hit  = lookup_en && valid_use && (tag_use == req_tag);
    assign miss = lookup_en && !hit;

    // Read word is zero for writes and when idle
    assign rdata = (lookup_en && !req_write) ? data_use[req_offset] : '0;

    // Victim is whatever sits at the index right now
    assign evict_dirty = valid_use && dirty_use;
    assign evict_addr  = block_addr(tag_use, req_index);
    assign evict_data  = data_use;

    // One enable per word and only the addressed one on a write hit
    for (genvar g = 0; g < `NUM_WORDS_PER_BLOCK; g++) begin : g_word
        assign word_we[g]     = req_write && hit && (req_offset == g);
        assign write_block[g] = fill_en ? fill_data[g] : req_wdata;  // Core word replicated
    end

    cache_data u_cache_data (
        .clk         (clk),
        .reset       (reset),
        .index       (req_index),
        .word_we     (word_we),
        .fill        (fill_en),
        .write_block (write_block),
        .write_tag   (req_tag),     // Fill installs the requested tag
        .tag_use     (tag_use),
        .data_use    (data_use),
        .valid_use   (valid_use),
        .dirty_use   (dirty_use)
    );

    // Shared write data mux serves either a fill or a core write
    a_lookup_fill_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(lookup_en && fill_en)
    ) else $error("cache_bank: lookup and fill in the same cycle");

    // A fill leaves the requested line valid and clean
    a_fill_installs_line: assert property (
        @(posedge clk) disable iff (reset)
        fill_en |=> (valid_use && (tag_use == req_tag) && !dirty_use)
    ) else $error("cache_bank: filled line not resident and clean");

endmodule

/* logic/cache_data.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line storage of the cache: tag, valid, dirty and data per index,
// read asynchronously, written by a full fill or by masked words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cache_defines.svh"

module cache_data import cache_addr_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  index_t                          index,
    input  logic [`NUM_WORDS_PER_BLOCK-1:0] word_we,     // One bit per word
    input  logic                            fill,        // Whole line from memory
    input  block_t                          write_block,
    input  tag_t                            write_tag,
    output tag_t                            tag_use,
    output block_t                          data_use,
    output logic                            valid_use,
    output logic                            dirty_use
);

    // Storage, tags and data carry no reset
    tag_t   tag_mem  [`NUM_INDEXES];
    block_t data_mem [`NUM_INDEXES];

    logic [`NUM_INDEXES-1:0] valid_bits;
    logic [`NUM_INDEXES-1:0] dirty_bits;

    // Combinational read of the indexed line
    assign tag_use   = tag_mem[index];
    assign data_use  = data_mem[index];
    assign valid_use = valid_bits[index];
    assign dirty_use = dirty_bits[index];

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[index] <= write_tag;  // New owner of the line
        end
        for (int w = 0; w < `NUM_WORDS_PER_BLOCK; w++) begin
            if (fill || word_we[w]) begin
                data_mem[index][w] <= write_block[w];
            end
        end
    end

    // Line state bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;  // Every line empty
            dirty_bits <= '0;
        end else if (fill) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0;  // Refilled clean
        end else if (word_we != '0) begin
            dirty_bits[index] <= 1'b1;  // Write hit, owes a write-back
        end
    end

    // A refill and a core write to the same line in one cycle would lose data
    a_fill_no_word_write: assert property (
        @(posedge clk) disable iff (reset)
        !(fill && (word_we != '0))
    ) else $error("cache_data: fill and word write together");

endmodule

/* logic/cache_ctrl_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Miss FSM state encoding, used by the cache controller only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cache_ctrl_pkg;

    // Memory pulse is presented during SEND_WB and SEND_FETCH
    typedef enum logic [1:0] {
        IDLE       = 2'd0,  // Lookup, hit response
        SEND_WB    = 2'd1,  // Posted write of the dirty victim
        SEND_FETCH = 2'd2,  // Block read request out
        RECV_FILL  = 2'd3   // Waiting on mem_rsp_valid
    } ctrl_state_t;

    // Every state is reachable, no spare encodings

endpackage

/* logic/cache_addr_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address, word and block types plus the field extraction helpers;
// imported by wildcard into every cache RTL module
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cache_defines.svh"

package cache_addr_pkg;

    typedef logic [`WORD_WIDTH-1:0]   word_t;
    typedef logic [`WORD_WIDTH-1:0]   addr_t;    // Byte address
    typedef logic [`TAG_WIDTH-1:0]    tag_t;
    typedef logic [`INDEX_WIDTH-1:0]  index_t;
    typedef logic [`OFFSET_WIDTH-1:0] offset_t;
    typedef logic [`NUM_WORDS_PER_BLOCK-1:0][`WORD_WIDTH-1:0] block_t;  // Word 0 in the low bits

    // Byte select bits below the word offset, unused by the cache
    localparam int BYTE_BITS = `WORD_WIDTH - `TAG_WIDTH - `INDEX_WIDTH - `OFFSET_WIDTH;

    function automatic tag_t addr_tag(addr_t addr);
        return addr[`WORD_WIDTH-1 -: `TAG_WIDTH];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[BYTE_BITS+`OFFSET_WIDTH +: `INDEX_WIDTH];
    endfunction

    function automatic offset_t addr_offset(addr_t addr);
        return addr[BYTE_BITS +: `OFFSET_WIDTH];
    endfunction

    // Block aligned address, offset and byte bits zero
    function automatic addr_t block_addr(tag_t tag, index_t index);
        return {tag, index, {(`OFFSET_WIDTH+BYTE_BITS){1'b0}}};
    endfunction

endpackage

/* logic/cache_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Geometry macros for the direct-mapped data cache, included by the
// address package and by every RTL file that sizes arrays or loops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Line geometry
`define NUM_WORDS_PER_BLOCK 4    // Words in one line
`define NUM_INDEXES         256  // Lines in the cache

// Address split, byte bits are what is left over
`define INDEX_WIDTH         8
`define OFFSET_WIDTH        2    // Word offset inside the line
`define TAG_WIDTH           20

// Data path
`define WORD_WIDTH          32

`endif
